// File: l2_cache_pkg.sv
/* Geometry constants and shared types for the L2 cache.
   Modules refer to these by scoped names. */

package l2_cache_pkg;

    localparam int num_ways = 4;
    localparam int num_sets = 8;
    localparam int line_bits = 256;

    // Address split, tag:index:offset
    localparam int offset_bits = 5;
    localparam int index_bits = 3;
    localparam int tag_bits = 24;

    // One address word seen whole or split into fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_bits-1:0] tag;
            logic [index_bits-1:0] index;
            logic [offset_bits-1:0] offset;
        } fields;
    } l2_addr_u;

    // Tree pseudo-LRU state
    // [2] root, [1] ways 0/1, [0] ways 2/3
    typedef logic [2:0] lru_t;

    // Source of pmem_address
    typedef enum logic {
        cache_read_mem = 1'b0,
        ewb_write_mem = 1'b1
    } pmem_addr_sel_t;

endpackage : l2_cache_pkg

// File: perf_counter.sv
/* Saturating event counter with a sticky overflow flag. */

`timescale 1ns/1ps

module perf_counter #(
    parameter int perf_width = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  count,
    output logic                  overflow,
    output logic [perf_width-1:0] out
);

always_ff @(posedge clk)
begin
    if (rst)
    begin
        out <= '0;
        overflow <= 1'b0;
    end
    else if (count)
    begin
        if (&out)
            overflow <= 1'b1; // Held at all ones
        else
            out <= out + 1'b1;
    end
end

endmodule : perf_counter

// File: l2_ewb.sv
/* One-entry eviction write buffer. Holds a pending line write until the
   controller drains it to memory, and serves reads that match it. */

`timescale 1ns/1ps

module l2_ewb (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              load_ewb,
    input  logic                              wb_ewb,
    input  logic                              tag_check,
    input  l2_cache_pkg::l2_addr_u            address,
    input  logic [l2_cache_pkg::line_bits-1:0] wdata,
    output logic                              ewb_valid,
    output logic                              ewb_hit,
    output l2_cache_pkg::l2_addr_u            ewb_address,
    output logic [l2_cache_pkg::line_bits-1:0] ewb_data
);

always_ff @(posedge clk)
begin
    if (rst)
    begin
        ewb_valid <= 1'b0;
    end
    else if (load_ewb)
    begin
        ewb_valid <= 1'b1;
    end
    else if (wb_ewb)
    begin
        ewb_valid <= 1'b0; // Drained to memory
    end
end

always_ff @(posedge clk)
begin
    if (load_ewb)
    begin
        ewb_address <= address;
        ewb_data <= wdata;
    end
end

// Whole line address must match
assign ewb_hit = tag_check && ewb_valid && (address.raw == ewb_address.raw);

// Controller may only drain a full buffer
assert property (@(posedge clk) disable iff (rst) wb_ewb |-> ewb_valid)
    else $error("EWB drained while empty");

// A full buffer is drained before it is loaded again
assert property (@(posedge clk) disable iff (rst) load_ewb |-> !ewb_valid)
    else $error("EWB loaded while still holding a write");

endmodule : l2_ewb

// File: l2_cache_datapath.sv
/* Tag, valid, LRU and data arrays of the 4-way L2 cache, with hit
   detection and the output line mux. Written only by refills and invalidates. */

`timescale 1ns/1ps

module l2_cache_datapath (
    input  logic                               clk,
    input  logic                               rst,
    input  l2_cache_pkg::l2_addr_u             address,
    input  logic [l2_cache_pkg::line_bits-1:0] pmem_rdata,

    input  logic valid_load_0,
    input  logic valid_load_1,
    input  logic valid_load_2,
    input  logic valid_load_3,
    input  logic valid_datain_0,
    input  logic valid_datain_1,
    input  logic valid_datain_2,
    input  logic valid_datain_3,
    input  logic tag_load_0,
    input  logic tag_load_1,
    input  logic tag_load_2,
    input  logic tag_load_3,
    input  logic data_load_0,
    input  logic data_load_1,
    input  logic data_load_2,
    input  logic data_load_3,

    input  logic                               lru_load,
    input  l2_cache_pkg::lru_t                 lru_datain,
    input  logic [1:0]                         dataout_sel,
    output logic                               hit,
    output logic [3:0]                         way_hit,
    output logic [3:0]                         valid_dataout,
    output l2_cache_pkg::lru_t                 lru_dataout,
    output logic [l2_cache_pkg::line_bits-1:0] dataout
);

localparam int ways = l2_cache_pkg::num_ways;
localparam int sets = l2_cache_pkg::num_sets;

logic [l2_cache_pkg::index_bits-1:0] idx;
logic [ways-1:0] valid_load_v;
logic [ways-1:0] valid_datain_v;
logic [ways-1:0] tag_load_v;
logic [ways-1:0] data_load_v;
logic [l2_cache_pkg::line_bits-1:0] way_data [ways];
l2_cache_pkg::lru_t lru_q [sets];

assign idx = address.fields.index;

assign valid_load_v = {valid_load_3, valid_load_2, valid_load_1, valid_load_0};
assign valid_datain_v = {valid_datain_3, valid_datain_2, valid_datain_1, valid_datain_0};
assign tag_load_v = {tag_load_3, tag_load_2, tag_load_1, tag_load_0};
assign data_load_v = {data_load_3, data_load_2, data_load_1, data_load_0};

for (genvar w = 0; w < ways; w++)
begin : g_way
    logic [sets-1:0] valid_q;
    logic [l2_cache_pkg::tag_bits-1:0] tag_q [sets];
    logic [l2_cache_pkg::line_bits-1:0] data_q [sets];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
            for (int s = 0; s < sets; s++)
            begin
                tag_q[s] <= '0;
                data_q[s] <= '0;
            end
        end
        else
        begin
            if (valid_load_v[w])
                valid_q[idx] <= valid_datain_v[w];
            if (tag_load_v[w])
                tag_q[idx] <= address.fields.tag;
            if (data_load_v[w])
                data_q[idx] <= pmem_rdata; // Refill line
        end
    end

    assign valid_dataout[w] = valid_q[idx];
    assign way_hit[w] = valid_q[idx] && (tag_q[idx] == address.fields.tag);
    assign way_data[w] = data_q[idx];
end

always_ff @(posedge clk)
begin
    if (rst)
    begin
        for (int s = 0; s < sets; s++)
            lru_q[s] <= '0;
    end
    else if (lru_load)
    begin
        lru_q[idx] <= lru_datain;
    end
end

assign lru_dataout = lru_q[idx];
assign hit = |way_hit;
assign dataout = way_data[dataout_sel];

// Controller never refills a line that is already present
assert property (@(posedge clk) disable iff (rst)
    !$isunknown(address.raw) |-> $onehot0(way_hit))
    else $error("Line cached in more than one way");

endmodule : l2_cache_datapath

// File: l2_cache_control.sv
/* L2 cache controller FSM. Sequences hits, refills, EWB loads and
   write-backs, picks victims by tree pseudo-LRU and counts read misses. */

`timescale 1ns/1ps

module l2_cache_control #(
    parameter int perf_width = 16,
    parameter int drain_delay = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic mem_read,
    input  logic mem_write,
    input  logic pmem_resp,
    input  logic ewb_hit,
    input  logic ewb_valid,
    input  logic hit,
    input  logic [3:0] way_hit,
    input  logic [3:0] valid_dataout,
    input  l2_cache_pkg::lru_t lru_dataout,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write,
    output logic tag_check,
    output logic load_ewb,
    output logic wb_ewb,
    output logic valid_load_0,
    output logic valid_load_1,
    output logic valid_load_2,
    output logic valid_load_3,
    output logic valid_datain_0,
    output logic valid_datain_1,
    output logic valid_datain_2,
    output logic valid_datain_3,
    output logic tag_load_0,
    output logic tag_load_1,
    output logic tag_load_2,
    output logic tag_load_3,
    output logic data_load_0,
    output logic data_load_1,
    output logic data_load_2,
    output logic data_load_3,
    output logic lru_load,
    output l2_cache_pkg::lru_t lru_datain,
    output logic [1:0] dataout_sel,
    output l2_cache_pkg::pmem_addr_sel_t pmem_address_sel,
    output logic [perf_width-1:0] l2_miss,
    output logic l2_miss_overflow
);

localparam int cnt_w = $clog2(drain_delay + 1);

localparam logic [2:0] DEFAULT = 3'd0;
localparam logic [2:0] EWB_LOAD = 3'd1;
localparam logic [2:0] COUNTDOWN = 3'd2;
localparam logic [2:0] WRITE_BACK = 3'd3;
localparam logic [2:0] HIT_DETECT = 3'd4;
localparam logic [2:0] MEM_READ = 3'd5;

logic [2:0] state;
logic [2:0] next_state;
logic [cnt_w-1:0] idle_cnt;
logic idle_done;
logic miss_strobe;
logic [1:0] hit_way;
logic [1:0] victim;
logic [3:0] valid_load_v;
logic [3:0] valid_datain_v;
logic [3:0] tag_load_v;
logic [3:0] data_load_v;

// Point the tree away from the way just used
function automatic l2_cache_pkg::lru_t lru_touch(input logic [1:0] way,
                                                 input l2_cache_pkg::lru_t cur);
    case (way)
        2'd0: lru_touch = {1'b0, 1'b0, cur[0]};
        2'd1: lru_touch = {1'b0, 1'b1, cur[0]};
        2'd2: lru_touch = {1'b1, cur[1], 1'b0};
        default: lru_touch = {1'b1, cur[1], 1'b1};
    endcase
endfunction

perf_counter #(.perf_width(perf_width)) miss_counter_i (
    .clk(clk),
    .rst(rst),
    .count(miss_strobe),
    .overflow(l2_miss_overflow),
    .out(l2_miss)
);

always_comb
begin
    hit_way = 2'd0;
    if (way_hit[1])
        hit_way = 2'd1;
    else if (way_hit[2])
        hit_way = 2'd2;
    else if (way_hit[3])
        hit_way = 2'd3;
end

always_comb
begin
    if (!valid_dataout[0])
        victim = 2'd0;
    else if (!valid_dataout[1])
        victim = 2'd1;
    else if (!valid_dataout[2])
        victim = 2'd2;
    else if (!valid_dataout[3])
        victim = 2'd3;
    else if (!lru_dataout[2])
        victim = lru_dataout[0] ? 2'd2 : 2'd3;
    else
        victim = lru_dataout[1] ? 2'd0 : 2'd1;
end

// Idle cycles spent in COUNTDOWN, restarted by any request
always_ff @(posedge clk)
begin
    if (rst || state != COUNTDOWN || mem_read || mem_write)
        idle_cnt <= '0;
    else
        idle_cnt <= idle_cnt + 1'b1;
end

assign idle_done = (idle_cnt == cnt_w'(drain_delay - 1));

always_comb
begin
    mem_resp = 1'b0;
    pmem_read = 1'b0;
    pmem_write = 1'b0;
    tag_check = 1'b0;
    load_ewb = 1'b0;
    wb_ewb = 1'b0;
    valid_load_v = '0;
    valid_datain_v = '0;
    tag_load_v = '0;
    data_load_v = '0;
    lru_load = 1'b0;
    lru_datain = lru_dataout;
    dataout_sel = hit_way;
    pmem_address_sel = l2_cache_pkg::cache_read_mem;
    miss_strobe = 1'b0;

    case (state)
        EWB_LOAD:
        begin
            load_ewb = 1'b1;
            mem_resp = 1'b1;
            valid_load_v = way_hit; // Drop the stale copy, if any
        end
        COUNTDOWN:
            tag_check = 1'b1;
        WRITE_BACK:
        begin
            pmem_write = 1'b1;
            pmem_address_sel = l2_cache_pkg::ewb_write_mem;
            wb_ewb = pmem_resp;
        end
        HIT_DETECT:
        begin
            tag_check = 1'b1;
            if (ewb_hit)
            begin
                mem_resp = 1'b1; // Data comes from the EWB
            end
            else if (hit)
            begin
                mem_resp = 1'b1;
                lru_load = 1'b1;
                lru_datain = lru_touch(hit_way, lru_dataout);
            end
            else
            begin
                miss_strobe = 1'b1;
            end
        end
        MEM_READ:
        begin
            pmem_read = 1'b1;
            if (pmem_resp)
            begin
                tag_load_v = 4'b0001 << victim;
                data_load_v = 4'b0001 << victim;
                valid_load_v = 4'b0001 << victim;
                valid_datain_v = 4'b0001 << victim;
                lru_load = 1'b1;
                lru_datain = lru_touch(victim, lru_dataout);
            end
        end
        default:;
    endcase
end

always_comb
begin
    next_state = state;
    case (state)
        DEFAULT:
        begin
            if (mem_write)
                next_state = ewb_valid ? WRITE_BACK : EWB_LOAD;
            else if (mem_read)
                next_state = HIT_DETECT;
            else if (ewb_valid)
                next_state = COUNTDOWN;
        end
        EWB_LOAD:
            next_state = COUNTDOWN;
        COUNTDOWN:
        begin
            if (mem_read)
                next_state = HIT_DETECT;
            else if (mem_write || idle_done)
                next_state = WRITE_BACK;
        end
        WRITE_BACK:
        begin
            if (pmem_resp)
                next_state = mem_write ? EWB_LOAD : DEFAULT;
        end
        HIT_DETECT:
        begin
            if (ewb_hit || hit)
                next_state = ewb_valid ? COUNTDOWN : DEFAULT;
            else
                next_state = MEM_READ;
        end
        MEM_READ:
        begin
            if (pmem_resp)
                next_state = HIT_DETECT; // Hits on the refilled way
        end
        default:
            next_state = DEFAULT;
    endcase
end

always_ff @(posedge clk)
begin
    if (rst)
        state <= DEFAULT;
    else
        state <= next_state;
end

assign valid_load_0 = valid_load_v[0];
assign valid_load_1 = valid_load_v[1];
assign valid_load_2 = valid_load_v[2];
assign valid_load_3 = valid_load_v[3];
assign valid_datain_0 = valid_datain_v[0];
assign valid_datain_1 = valid_datain_v[1];
assign valid_datain_2 = valid_datain_v[2];
assign valid_datain_3 = valid_datain_v[3];
assign tag_load_0 = tag_load_v[0];
assign tag_load_1 = tag_load_v[1];
assign tag_load_2 = tag_load_v[2];
assign tag_load_3 = tag_load_v[3];
assign data_load_0 = data_load_v[0];
assign data_load_1 = data_load_v[1];
assign data_load_2 = data_load_v[2];
assign data_load_3 = data_load_v[3];

// Response only ends a request the CPU still holds
assert property (@(posedge clk) disable iff (rst) mem_resp |-> (mem_read || mem_write))
    else $error("mem_resp without a CPU request");

endmodule : l2_cache_control

// File: l2_cache.sv
/* Top level of the L2 cache. Connects the controller, datapath and EWB,
   and selects the CPU read data and the memory address. */

`timescale 1ns/1ps

module l2_cache #(
    parameter int perf_width = 16,
    parameter int drain_delay = 2
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               mem_read,
    input  logic                               mem_write,
    input  logic [31:0]                        mem_address,
    input  logic [l2_cache_pkg::line_bits-1:0] mem_wdata,
    output logic [l2_cache_pkg::line_bits-1:0] mem_rdata,
    output logic                               mem_resp,
    output logic                               pmem_read,
    output logic                               pmem_write,
    output logic [31:0]                        pmem_address,
    output logic [l2_cache_pkg::line_bits-1:0] pmem_wdata,
    input  logic [l2_cache_pkg::line_bits-1:0] pmem_rdata,
    input  logic                               pmem_resp,
    output logic [perf_width-1:0]              l2_miss,
    output logic                               l2_miss_overflow
);

l2_cache_pkg::l2_addr_u req_addr;
l2_cache_pkg::l2_addr_u ewb_address;
l2_cache_pkg::lru_t lru_dataout;
l2_cache_pkg::lru_t lru_datain;
l2_cache_pkg::pmem_addr_sel_t pmem_address_sel;
logic [l2_cache_pkg::line_bits-1:0] dataout;
logic [l2_cache_pkg::line_bits-1:0] ewb_data;
logic tag_check, load_ewb, wb_ewb, ewb_hit, ewb_valid, hit, lru_load;
logic [3:0] way_hit;
logic [3:0] valid_dataout;
logic [1:0] dataout_sel;
logic valid_load_0, valid_load_1, valid_load_2, valid_load_3;
logic valid_datain_0, valid_datain_1, valid_datain_2, valid_datain_3;
logic tag_load_0, tag_load_1, tag_load_2, tag_load_3;
logic data_load_0, data_load_1, data_load_2, data_load_3;

assign req_addr.raw = mem_address;

l2_cache_control #(.perf_width(perf_width), .drain_delay(drain_delay)) control_i (
    .clk, .rst, .mem_read, .mem_write, .pmem_resp, .ewb_hit, .ewb_valid,
    .hit, .way_hit, .valid_dataout, .lru_dataout,
    .mem_resp, .pmem_read, .pmem_write, .tag_check, .load_ewb, .wb_ewb,
    .valid_load_0, .valid_load_1, .valid_load_2, .valid_load_3,
    .valid_datain_0, .valid_datain_1, .valid_datain_2, .valid_datain_3,
    .tag_load_0, .tag_load_1, .tag_load_2, .tag_load_3,
    .data_load_0, .data_load_1, .data_load_2, .data_load_3,
    .lru_load, .lru_datain, .dataout_sel, .pmem_address_sel,
    .l2_miss, .l2_miss_overflow
);

l2_cache_datapath datapath_i (
    .clk, .rst, .address(req_addr), .pmem_rdata,
    .valid_load_0, .valid_load_1, .valid_load_2, .valid_load_3,
    .valid_datain_0, .valid_datain_1, .valid_datain_2, .valid_datain_3,
    .tag_load_0, .tag_load_1, .tag_load_2, .tag_load_3,
    .data_load_0, .data_load_1, .data_load_2, .data_load_3,
    .lru_load, .lru_datain, .dataout_sel,
    .hit, .way_hit, .valid_dataout, .lru_dataout, .dataout
);

l2_ewb ewb_i (
    .clk, .rst, .load_ewb, .wb_ewb, .tag_check,
    .address(req_addr), .wdata(mem_wdata),
    .ewb_valid, .ewb_hit, .ewb_address, .ewb_data
);

assign mem_rdata = ewb_hit ? ewb_data : dataout; // Pending write wins
assign pmem_address = (pmem_address_sel == l2_cache_pkg::ewb_write_mem) ?
                      ewb_address.raw : req_addr.raw;
assign pmem_wdata = ewb_data;

endmodule : l2_cache

// File: tb_l2_cache.sv
/* Testbench for the L2 cache. Plays the L1 and physical memory, keeps a
   reference model of tags, LRU and the EWB, and checks the DUT with assertions. */

`timescale 1ns/1ps

module tb_l2_cache;

localparam int line_w = l2_cache_pkg::line_bits;
localparam int num_requests = 200;
localparam int timeout_cycles = num_requests * 12 + 8;

logic clk = 1'b0;
logic rst;
logic mem_read, mem_write, mem_resp, pmem_read, pmem_write, pmem_resp;
logic [31:0] mem_address, pmem_address;
logic [line_w-1:0] mem_wdata, mem_rdata, pmem_wdata, pmem_rdata;
logic [15:0] l2_miss;
logic l2_miss_overflow;

logic [line_w-1:0] phys_mem [logic [31:0]];
logic [line_w-1:0] golden [logic [31:0]]; // Updated as each write is issued
logic [31:0] wq_addr [$];                 // Writes not yet in memory, oldest first
logic [line_w-1:0] wq_data [$];
logic [3:0] sh_valid [8];
logic [23:0] sh_tag [8][4];
logic [2:0] sh_lru [8];
logic [15:0] lfsr_q = 16'd47;
int lat_left, cycle_cnt, checks_failed, req_age, wq_count;
logic mem_busy, resp_was_write, req_active, fast_exp;
logic [line_w-1:0] exp_rdata, exp_wr_data;
logic [31:0] exp_wr_addr;
logic [15:0] exp_miss;

// Drain delay longer than the widest gap between requests
l2_cache #(.perf_width(16), .drain_delay(5)) dut_i (
    .clk, .rst, .mem_read, .mem_write, .mem_address, .mem_wdata, .mem_rdata,
    .mem_resp, .pmem_read, .pmem_write, .pmem_address, .pmem_wdata,
    .pmem_rdata, .pmem_resp, .l2_miss, .l2_miss_overflow
);

always #2 clk = ~clk;

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
        lfsr_q = lfsr_next(lfsr_q);
        v = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
endfunction

function automatic logic [line_w-1:0] random_line();
    logic [line_w-1:0] l;
    for (int k = 0; k < 8; k++)
        l[k*32 +: 32] = 32'(take_bits(32));
    return l;
endfunction

function automatic logic [line_w-1:0] fill_line(input logic [31:0] a);
    return {8{a}}; // Untouched memory holds its own address
endfunction

function automatic logic [31:0] line_addr(input int tag, input int set);
    return {24'(tag), 3'(set), 5'd0};
endfunction

function automatic int shadow_victim(input logic [3:0] valid, input logic [2:0] lru);
    for (int w = 0; w < 4; w++)
        if (!valid[w])
            return w;
    if (!lru[2])
        return lru[0] ? 2 : 3;
    return lru[1] ? 0 : 1;
endfunction

function automatic logic [2:0] shadow_touch(input int way, input logic [2:0] lru);
    logic [2:0] n;
    n = lru;
    n[2] = (way >= 2);
    if (way < 2)
        n[1] = (way == 1);
    else
        n[0] = (way == 3);
    return n;
endfunction

task automatic stop_with_failure();
    checks_failed++;
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first failure");
endtask

task automatic refresh_write_expect();
    wq_count = wq_addr.size();
    if (wq_count != 0)
    begin
        exp_wr_addr = wq_addr[0];
        exp_wr_data = wq_data[0];
    end
endtask

// Memory model, one step per falling edge
task automatic serve_memory();
    if (pmem_resp)
    begin
        pmem_resp = 1'b0;
        mem_busy = 1'b0;
        if (resp_was_write)
        begin
            wq_addr.delete(0);
            wq_data.delete(0);
        end
    end
    else if (pmem_read || pmem_write)
    begin
        if (!mem_busy)
        begin
            mem_busy = 1'b1;
            lat_left = 1 + take_bits(2);
        end
        lat_left--;
        if (lat_left == 0)
        begin
            resp_was_write = pmem_write;
            if (pmem_write)
                phys_mem[pmem_address] = pmem_wdata;
            else if (phys_mem.exists(pmem_address))
                pmem_rdata = phys_mem[pmem_address];
            else
                pmem_rdata = fill_line(pmem_address);
            pmem_resp = 1'b1;
        end
    end
    refresh_write_expect();
endtask

task automatic tick();
    @(negedge clk);
    serve_memory();
    req_age++;
endtask

task automatic run_request(input logic is_write, input logic [31:0] addr,
                           input logic [line_w-1:0] wdata);
    logic [2:0] set;
    logic hit_found;
    logic ewb_match;
    int way;
    set = addr[7:5];
    hit_found = 1'b0;
    way = 0;
    for (int w = 0; w < 4; w++)
    begin
        if (sh_valid[set][w] && sh_tag[set][w] == addr[31:8])
        begin
            hit_found = 1'b1;
            way = w;
        end
    end
    // A drain in progress empties the EWB before this request is seen
    ewb_match = wq_count != 0 && !pmem_write && wq_addr[$] == addr;
    if (is_write)
    begin
        fast_exp = (wq_count == 0);
        if (hit_found)
            sh_valid[set][way] = 1'b0;
        golden[addr] = wdata;
        wq_addr.push_back(addr);
        wq_data.push_back(wdata);
        refresh_write_expect();
    end
    else
    begin
        exp_rdata = golden.exists(addr) ? golden[addr] : fill_line(addr);
        fast_exp = ewb_match || (hit_found && !pmem_write);
        if (!ewb_match)
        begin
            if (!hit_found)
            begin
                way = shadow_victim(sh_valid[set], sh_lru[set]);
                sh_valid[set][way] = 1'b1;
                sh_tag[set][way] = addr[31:8];
                exp_miss++;
            end
            sh_lru[set] = shadow_touch(way, sh_lru[set]);
        end
    end
    mem_address = addr;
    mem_wdata = wdata;
    mem_write = is_write;
    mem_read = !is_write;
    req_age = 0;
    req_active = 1'b1;
    tick();
    while (!mem_resp)
        tick();
    tick();
    mem_read = 1'b0;
    mem_write = 1'b0;
    req_active = 1'b0;
    repeat (1 + take_bits(2)) tick();
endtask

always @(posedge clk)
begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles)
    begin
        $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
        stop_with_failure();
    end
end

assert property (@(posedge clk) disable iff (rst)
    (mem_resp && mem_read) |-> mem_rdata == exp_rdata)
    else begin
        $display("MISMATCH t=%0t mem_rdata got=%h exp=%h", $time, mem_rdata, exp_rdata);
        stop_with_failure();
    end

assert property (@(posedge clk) disable iff (rst) $past(mem_resp) |-> !mem_resp)
    else begin
        $display("mem_resp stayed high for more than one cycle at t=%0t", $time);
        stop_with_failure();
    end

assert property (@(posedge clk) disable iff (rst) (req_active && req_age == 0) |-> !mem_resp)
    else begin
        $display("MISMATCH t=%0t mem_resp got=1 exp=0", $time);
        stop_with_failure();
    end

// Hits, EWB hits and writes into an empty EWB answer in the next cycle
assert property (@(posedge clk) disable iff (rst)
    (req_active && fast_exp && req_age == 1) |-> mem_resp)
    else begin
        $display("MISMATCH t=%0t mem_resp got=0 exp=1", $time);
        stop_with_failure();
    end

assert property (@(posedge clk) disable iff (rst) mem_resp |-> l2_miss == exp_miss)
    else begin
        $display("MISMATCH t=%0t l2_miss got=%0d exp=%0d", $time, l2_miss, exp_miss);
        stop_with_failure();
    end

// Far fewer misses than the counter can hold
assert property (@(posedge clk) disable iff (rst) !l2_miss_overflow)
    else begin
        $display("MISMATCH t=%0t l2_miss_overflow got=%b exp=0", $time, l2_miss_overflow);
        stop_with_failure();
    end

assert property (@(posedge clk) disable iff (rst) pmem_write |-> wq_count != 0)
    else begin
        $display("Memory write at t=%0t with no CPU write pending", $time);
        stop_with_failure();
    end

assert property (@(posedge clk) disable iff (rst)
    (pmem_write && wq_count != 0) |-> pmem_address == exp_wr_addr)
    else begin
        $display("MISMATCH t=%0t pmem_address got=%h exp=%h", $time, pmem_address, exp_wr_addr);
        stop_with_failure();
    end

assert property (@(posedge clk) disable iff (rst)
    (pmem_write && wq_count != 0) |-> pmem_wdata == exp_wr_data)
    else begin
        $display("MISMATCH t=%0t pmem_wdata got=%h exp=%h", $time, pmem_wdata, exp_wr_data);
        stop_with_failure();
    end

assert property (@(posedge clk) disable iff (rst) !(pmem_read && pmem_write))
    else begin
        $display("pmem_read and pmem_write high together at t=%0t", $time);
        stop_with_failure();
    end

assert property (@(posedge clk)
    $fell(rst) |-> (!mem_resp && !pmem_read && !pmem_write && l2_miss == '0))
    else begin
        $display("Outputs not cleared by reset at t=%0t", $time);
        stop_with_failure();
    end

initial
begin
    int t;
    int s;
    rst = 1'b1;
    mem_read = 1'b0;
    mem_write = 1'b0;
    mem_address = '0;
    mem_wdata = '0;
    pmem_resp = 1'b0;
    pmem_rdata = '0;
    mem_busy = 1'b0;
    resp_was_write = 1'b0;
    req_active = 1'b0;
    fast_exp = 1'b0;
    exp_miss = '0;
    exp_rdata = '0;
    refresh_write_expect();
    for (int i = 0; i < 8; i++)
    begin
        sh_valid[i] = '0;
        sh_lru[i] = '0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Five tags in one set force an eviction, then revisits test the tree
    for (int i = 0; i < 5; i++)
        run_request(1'b0, line_addr(16 + i, 5), '0);
    run_request(1'b0, line_addr(16, 5), '0);
    run_request(1'b0, line_addr(19, 5), '0);
    run_request(1'b0, line_addr(17, 5), '0);
    run_request(1'b1, line_addr(18, 5), random_line());
    run_request(1'b0, line_addr(18, 5), '0); // Served by the EWB
    while (wq_count != 0)
        tick();
    run_request(1'b0, line_addr(18, 5), '0);

    for (int n = 11; n < num_requests; n++)
    begin
        t = take_bits(3) % 6;
        s = take_bits(1) ? 5 : 2;
        if (take_bits(2) == 0)
            run_request(1'b1, line_addr(16 + t, s), random_line());
        else
            run_request(1'b0, line_addr(16 + t, s), '0);
    end
    while (wq_count != 0)
        tick();

    if (checks_failed == 0)
    begin
        $display(">>> PASS");
        $finish;
    end
    else
    begin
        stop_with_failure();
    end
end

endmodule : tb_l2_cache

// File: compile.f
l2_cache_pkg.sv
perf_counter.sv
l2_ewb.sv
l2_cache_datapath.sv
l2_cache_control.sv
l2_cache.sv
tb_l2_cache.sv

// File: Makefile
# Verilator build and run of the L2 cache testbench

VERILATOR ?= verilator
TOP       ?= tb_l2_cache
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
